//--- src/if_pkg.sv
// Fetch control package
// Redirect source encoding, datapath widths and the constants of
// the dummy instruction generator

`default_nettype none

package if_pkg;

  ////////////////////
  // Datapath widths
  ////////////////////

  // Address and instruction data width
  localparam int XLEN = 32;

  // Trap base field, the trap address is this field followed by 7 zero bits
  localparam int MTVEC_ADDR_W = 25;

  ////////////////////
  // Redirect sources
  ////////////////////

  typedef enum logic [2:0] {
    PC_BOOT   = 3'd0,
    PC_JUMP   = 3'd1,
    PC_BRANCH = 3'd2,
    PC_MRET   = 3'd3,
    PC_TRAP   = 3'd4
  } pc_mux_e;

  ////////////////////
  // Dummy insertion
  ////////////////////

  localparam int LFSR_W = 16;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;
  // Fibonacci taps 16, 14, 13, 11 as bit positions 15, 13, 12, 10
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

  // Width of the dummy spacing setting
  localparam int DUMMY_CNT_W = 4;

endpackage

`default_nettype wire

//--- src/rvc_pkg.sv
// Instruction encoding package
// Major opcodes, compressed quadrant and funct3 codes, and the
// instruction word seen either as a 32-bit or a compressed encoding

`default_nettype none

package rvc_pkg;

  ////////////////////
  // Major opcodes
  ////////////////////

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  ////////////////////
  // Compressed codes
  ////////////////////

  // Quadrant in bits 1:0, 2'b11 marks a 32-bit instruction
  localparam logic [1:0] C_QUAD_0 = 2'b00;
  localparam logic [1:0] C_QUAD_1 = 2'b01;
  localparam logic [1:0] C_QUAD_2 = 2'b10;

  // Quadrant 1 funct3
  localparam logic [2:0] C_F3_ADDI   = 3'b000;
  localparam logic [2:0] C_F3_LI     = 3'b010;
  localparam logic [2:0] C_F3_LUI    = 3'b011;
  // Quadrant 2 funct3, shared by C.MV and C.ADD (bit 12 tells them apart)
  localparam logic [2:0] C_F3_MV_ADD = 3'b100;

  ////////////////////
  // Instruction word
  ////////////////////

  // 32-bit I/R type fields, the I type immediate is {funct7, rs2}
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_base_t;

  // Compressed fields in the low half-word
  typedef struct packed {
    logic [15:0] upper;
    logic [2:0]  funct3;
    logic        b12;
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2_imm;
    logic [1:0]  quad;
  } instr_comp_t;

  typedef union packed {
    instr_base_t base;
    instr_comp_t comp;
  } instr_word_u;

endpackage

`default_nettype wire

//--- src/if_fetch_unit.sv
// Fetch unit
// Holds the program counter, picks the redirect target and steps
// the PC by the size of each issued instruction

`timescale 1ns/1ps
`default_nettype none

module if_fetch_unit (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               pc_set_i,
  input  wire if_pkg::pc_mux_e              pc_mux_i,
  input  wire [if_pkg::XLEN-1:0]            boot_addr_i,
  input  wire [if_pkg::XLEN-1:0]            jump_target_i,
  input  wire [if_pkg::XLEN-1:0]            branch_target_i,
  input  wire [if_pkg::XLEN-1:0]            mepc_i,
  input  wire [if_pkg::MTVEC_ADDR_W-1:0]    mtvec_addr_i,
  input  wire                               issue_i,
  input  wire                               dummy_insert_i,
  input  wire                               is_compressed_i,
  output logic [if_pkg::XLEN-1:0]           instr_addr_o,
  output logic [if_pkg::XLEN-1:0]           fetch_pc_o,
  output logic                              fetch_valid_o
);

  logic [if_pkg::XLEN-1:0] redirect_addr;
  logic [if_pkg::XLEN-1:0] pc_step;
  logic [if_pkg::XLEN-1:0] pc_q;
  logic                    valid_q;

  // Redirect target selection
  always_comb begin
    case (pc_mux_i)
      if_pkg::PC_JUMP:   redirect_addr = jump_target_i;
      if_pkg::PC_BRANCH: redirect_addr = branch_target_i;
      if_pkg::PC_MRET:   redirect_addr = mepc_i;
      // Traps go to the aligned base
      if_pkg::PC_TRAP:   redirect_addr = {mtvec_addr_i, 7'b0};
      default:           redirect_addr = boot_addr_i;
    endcase
  end

  // Half-word step for compressed, full word otherwise
  assign pc_step = {{(if_pkg::XLEN-3){1'b0}}, (is_compressed_i ? 3'd2 : 3'd4)};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else if (pc_set_i) begin
      // Bit 0 of a target is always dropped
      pc_q    <= {redirect_addr[if_pkg::XLEN-1:1], 1'b0};
      valid_q <= 1'b1;
    end else if (issue_i && !dummy_insert_i) begin
      pc_q <= pc_q + pc_step;
    end
  end

  // ROM answers in the same cycle
  assign instr_addr_o  = pc_q;
  assign fetch_pc_o    = pc_q;
  assign fetch_valid_o = valid_q;

endmodule

`default_nettype wire

//--- src/rvc_expander.sv
// Compressed instruction expander
// Maps C.ADDI, C.LI, C.LUI, C.MV and C.ADD to their 32-bit forms,
// flags every other compressed word as illegal

`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
  input  wire rvc_pkg::instr_word_u instr_i,
  output rvc_pkg::instr_word_u      instr_o,
  output logic                      is_compressed_o,
  output logic                      illegal_o
);

  logic [2:0] c_funct3;
  logic       c_b12;
  logic [4:0] c_rd;
  logic [4:0] c_rs2;
  logic [1:0] c_quad;

  // Compressed view of the low half-word
  assign c_funct3 = instr_i.comp.funct3;
  assign c_b12    = instr_i.comp.b12;
  assign c_rd     = instr_i.comp.rd_rs1;
  assign c_rs2    = instr_i.comp.rs2_imm;
  assign c_quad   = instr_i.comp.quad;

  // Anything outside quadrant 3 is 16 bits wide
  assign is_compressed_o = (c_quad != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      instr_o   = '0;
      illegal_o = 1'b1;

      case (c_quad)
        rvc_pkg::C_QUAD_1: begin
          case (c_funct3)
            // addi rd, rd, simm
            rvc_pkg::C_F3_ADDI: begin
              instr_o.base.funct7 = {7{c_b12}};
              instr_o.base.rs2    = c_rs2;
              instr_o.base.rs1    = c_rd;
              instr_o.base.rd     = c_rd;
              instr_o.base.opcode = rvc_pkg::OPC_OP_IMM;
              illegal_o           = 1'b0;
            end
            // addi rd, x0, simm
            rvc_pkg::C_F3_LI: begin
              instr_o.base.funct7 = {7{c_b12}};
              instr_o.base.rs2    = c_rs2;
              instr_o.base.rd     = c_rd;
              instr_o.base.opcode = rvc_pkg::OPC_OP_IMM;
              illegal_o           = 1'b0;
            end
            // lui rd, simm with imm[31:17] sign copies
            rvc_pkg::C_F3_LUI: begin
              instr_o.base.funct7 = {7{c_b12}};
              instr_o.base.rs2    = {5{c_b12}};
              instr_o.base.rs1    = {{3{c_b12}}, c_rs2[4:3]};
              instr_o.base.funct3 = c_rs2[2:0];
              instr_o.base.rd     = c_rd;
              instr_o.base.opcode = rvc_pkg::OPC_LUI;
              // x2 form is C.ADDI16SP, zero immediate is reserved
              illegal_o = (c_rd == 5'd2) || ({c_b12, c_rs2} == 6'd0);
            end
            default: ;
          endcase
        end

        rvc_pkg::C_QUAD_2: begin
          if (c_funct3 == rvc_pkg::C_F3_MV_ADD) begin
            // C.MV reads x0, C.ADD reads rd
            instr_o.base.rs2    = c_rs2;
            instr_o.base.rs1    = c_b12 ? c_rd : 5'd0;
            instr_o.base.rd     = c_rd;
            instr_o.base.opcode = rvc_pkg::OPC_OP;
            // rs2 of zero encodes jr, jalr or ebreak
            illegal_o = (c_rs2 == 5'd0);
          end
        end

        // No quadrant 0 instruction is expanded
        rvc_pkg::C_QUAD_0: illegal_o = 1'b1;
        default: ;
      endcase

      if (illegal_o) begin
        instr_o = '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dummy_insert_gen.sv
// Dummy instruction generator
// Counts issued real instructions and requests a dummy addi x0 with
// an LFSR immediate after every dummy_every_i of them

`timescale 1ns/1ps
`default_nettype none

module dummy_insert_gen (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire [if_pkg::DUMMY_CNT_W-1:0]   dummy_every_i,
  input  wire                             issue_i,
  output logic                            dummy_insert_o,
  output rvc_pkg::instr_word_u            dummy_word_o
);

  logic [if_pkg::DUMMY_CNT_W-1:0] cnt_q;
  logic [if_pkg::LFSR_W-1:0]      lfsr_q;
  logic                           lfsr_fb;

  // Request holds until the dummy is taken
  assign dummy_insert_o = (dummy_every_i != '0) && (cnt_q == dummy_every_i);

  // Fibonacci feedback into bit 0
  assign lfsr_fb = ^(lfsr_q & if_pkg::LFSR_TAPS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      lfsr_q <= if_pkg::LFSR_SEED;
    end else if (dummy_every_i == '0) begin
      // Disabled, nothing counted
      cnt_q <= '0;
    end else if (issue_i) begin
      if (dummy_insert_o) begin
        cnt_q  <= '0;
        lfsr_q <= {lfsr_q[if_pkg::LFSR_W-2:0], lfsr_fb};
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // addi x0, x0, lfsr[11:0]
  always_comb begin
    dummy_word_o             = '0;
    dummy_word_o.base.funct7 = lfsr_q[11:5];
    dummy_word_o.base.rs2    = lfsr_q[4:0];
    dummy_word_o.base.opcode = rvc_pkg::OPC_OP_IMM;
  end

endmodule

`default_nettype wire

//--- src/if_id_regs.sv
// IF/ID pipeline register
// Decides the issue and captures either the dummy or the expanded
// instruction, frozen while decode is not ready

`timescale 1ns/1ps
`default_nettype none

module if_id_regs (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        fetch_valid_i,
  input  wire                        id_ready_i,
  input  wire                        halt_i,
  input  wire                        pc_set_i,
  input  wire [if_pkg::XLEN-1:0]     fetch_pc_i,
  input  wire rvc_pkg::instr_word_u  instr_i,
  input  wire                        is_compressed_i,
  input  wire                        illegal_i,
  input  wire                        dummy_insert_i,
  input  wire rvc_pkg::instr_word_u  dummy_word_i,
  output logic                       issue_o,
  output logic                       id_valid_o,
  output rvc_pkg::instr_word_u       id_instr_o,
  output logic [if_pkg::XLEN-1:0]    id_pc_o,
  output logic                       id_compressed_o,
  output logic                       id_illegal_o,
  output logic                       id_dummy_o
);

  // Word in flight is stale when a redirect lands
  assign issue_o = fetch_valid_i && id_ready_i && !halt_i && !pc_set_i;

  ////////////////////
  // Control flags
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o      <= 1'b0;
      id_compressed_o <= 1'b0;
      id_illegal_o    <= 1'b0;
      id_dummy_o      <= 1'b0;
    end else if (issue_o) begin
      id_valid_o      <= 1'b1;
      // Dummies are plain 32-bit legal words
      id_compressed_o <= dummy_insert_i ? 1'b0 : is_compressed_i;
      id_illegal_o    <= dummy_insert_i ? 1'b0 : illegal_i;
      id_dummy_o      <= dummy_insert_i;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (issue_o) begin
      id_instr_o <= dummy_insert_i ? dummy_word_i : instr_i;
      // Dummy reuses the PC of the held instruction
      id_pc_o    <= fetch_pc_i;
    end
  end

endmodule

`default_nettype wire

//--- src/if_stage_top.sv
// Instruction fetch stage top
// Fetch unit feeding the expander and dummy generator side by side,
// results merged in the IF/ID register

`timescale 1ns/1ps
`default_nettype none

module if_stage_top (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               pc_set_i,
  input  wire if_pkg::pc_mux_e              pc_mux_i,
  input  wire [if_pkg::XLEN-1:0]            boot_addr_i,
  input  wire [if_pkg::XLEN-1:0]            jump_target_i,
  input  wire [if_pkg::XLEN-1:0]            branch_target_i,
  input  wire [if_pkg::XLEN-1:0]            mepc_i,
  input  wire [if_pkg::MTVEC_ADDR_W-1:0]    mtvec_addr_i,
  input  wire                               halt_i,
  input  wire [if_pkg::DUMMY_CNT_W-1:0]     dummy_every_i,
  input  wire                               id_ready_i,
  output logic [if_pkg::XLEN-1:0]           instr_addr_o,
  input  wire [if_pkg::XLEN-1:0]            instr_rdata_i,
  output logic                              id_valid_o,
  output logic [if_pkg::XLEN-1:0]           id_instr_o,
  output logic [if_pkg::XLEN-1:0]           id_pc_o,
  output logic                              id_compressed_o,
  output logic                              id_illegal_o,
  output logic                              id_dummy_o
);

  logic                    fetch_valid;
  logic [if_pkg::XLEN-1:0] fetch_pc;
  logic                    is_compressed;
  logic                    illegal;
  logic [if_pkg::XLEN-1:0] expanded_instr;
  logic                    dummy_insert;
  logic [if_pkg::XLEN-1:0] dummy_word;
  logic                    issue;

  if_fetch_unit if_fetch_unit_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .issue_i         (issue),
    .dummy_insert_i  (dummy_insert),
    .is_compressed_i (is_compressed),
    .instr_addr_o    (instr_addr_o),
    .fetch_pc_o      (fetch_pc),
    .fetch_valid_o   (fetch_valid)
  );

  // ROM word straight into the expander
  rvc_expander rvc_expander_inst (
    .instr_i         (instr_rdata_i),
    .instr_o         (expanded_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (illegal)
  );

  dummy_insert_gen dummy_insert_gen_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_every_i  (dummy_every_i),
    .issue_i        (issue),
    .dummy_insert_o (dummy_insert),
    .dummy_word_o   (dummy_word)
  );

  if_id_regs if_id_regs_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_valid_i   (fetch_valid),
    .id_ready_i      (id_ready_i),
    .halt_i          (halt_i),
    .pc_set_i        (pc_set_i),
    .fetch_pc_i      (fetch_pc),
    .instr_i         (expanded_instr),
    .is_compressed_i (is_compressed),
    .illegal_i       (illegal),
    .dummy_insert_i  (dummy_insert),
    .dummy_word_i    (dummy_word),
    .issue_o         (issue),
    .id_valid_o      (id_valid_o),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o),
    .id_illegal_o    (id_illegal_o),
    .id_dummy_o      (id_dummy_o)
  );

endmodule

`default_nettype wire

//--- include/if_stage_tb_table.svh
// Fetch stage testbench table
// Redirect targets, ROM contents and the per-cycle stimulus with the
// ID outputs expected after that cycle's rising edge

`ifndef IF_STAGE_TB_TABLE_SVH
`define IF_STAGE_TB_TABLE_SVH

////////////////////
// Redirect targets
////////////////////

localparam logic [31:0] BOOT_ADDR   = 32'h0000_0040;
localparam logic [31:0] JUMP_ADDR   = 32'h0000_0100;
localparam logic [31:0] BRANCH_ADDR = 32'h0000_0080;
// Odd on purpose, fetch lands on 0xC0
localparam logic [31:0] MEPC_ADDR   = 32'h0000_00C1;
// Trap target 3 << 7 = 0x180
localparam logic [if_pkg::MTVEC_ADDR_W-1:0] MTVEC_BASE = 25'd3;

// Short redirect codes for the table
localparam logic [2:0] M_BT = 3'(if_pkg::PC_BOOT);
localparam logic [2:0] M_JP = 3'(if_pkg::PC_JUMP);
localparam logic [2:0] M_BR = 3'(if_pkg::PC_BRANCH);
localparam logic [2:0] M_MR = 3'(if_pkg::PC_MRET);
localparam logic [2:0] M_TR = 3'(if_pkg::PC_TRAP);

////////////////////
// ROM contents
////////////////////

// Every fill half-word ends in 2'b11, so any fetch from fill is a 32-bit addi
function automatic logic [15:0] rom_fill(input logic [7:0] idx);
  return {idx, 8'h13};
endfunction

// Half-word index in bits 23:16, compressed encoding below
localparam int ROM_PATCHES = 7;
localparam logic [23:0] ROM_PATCH [ROM_PATCHES] = '{
  24'h26_12F5,  // C.ADDI x5, -3 at 0x4C
  24'h27_431D,  // C.LI x6, 7
  24'h28_6389,  // C.LUI x7, 2
  24'h29_8426,  // C.MV x8, x9
  24'h2A_952E,  // C.ADD x10, x11
  24'h2B_6109,  // C.LUI x2, reserved
  24'h2C_4188   // Quadrant 0 c.lw, not expanded
};

////////////////////
// Stimulus table
////////////////////

typedef struct packed {
  logic [2:0]  test;
  logic        pc_set;
  logic [2:0]  mux;
  logic        halt;
  logic        ready;
  logic [3:0]  every;
  logic        chk;
  logic        lfsr;
  logic        valid;
  logic [31:0] pc;
  logic [31:0] instr;
  logic [2:0]  flags;
} row_t;

// test, pc_set, mux, halt, ready, every, chk, lfsr, valid, pc, instr, flags
// chk clear means only id_valid_o is compared, flags are {compressed, illegal, dummy}
// lfsr set means the expected word comes from the LFSR model
localparam int NUM_ROWS = 34;
localparam row_t STIM_TABLE [NUM_ROWS] = '{
  '{3'd1, 1'b1, M_BT, 1'b0, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3'b000},
  '{3'd1, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h40, 32'h21132013, 3'b000},
  '{3'd1, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h44, 32'h23132213, 3'b000},
  '{3'd1, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h48, 32'h25132413, 3'b000},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h4C, 32'hFFD28293, 3'b100},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h4E, 32'h00700313, 3'b100},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h50, 32'h000023B7, 3'b100},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h52, 32'h00900433, 3'b100},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h54, 32'h00B50533, 3'b100},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h56, 32'h0, 3'b110},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h58, 32'h0, 3'b110},
  '{3'd2, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h5A, 32'h2E132D13, 3'b000},
  '{3'd4, 1'b0, M_BT, 1'b0, 1'b0, 4'd0, 1'b1, 1'b0, 1'b1, 32'h5A, 32'h2E132D13, 3'b000},
  '{3'd4, 1'b0, M_BT, 1'b0, 1'b0, 4'd0, 1'b1, 1'b0, 1'b1, 32'h5A, 32'h2E132D13, 3'b000},
  '{3'd4, 1'b0, M_BT, 1'b1, 1'b1, 4'd0, 1'b1, 1'b0, 1'b0, 32'h5A, 32'h2E132D13, 3'b000},
  '{3'd4, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h5E, 32'h30132F13, 3'b000},
  '{3'd3, 1'b1, M_JP, 1'b0, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3'b000},
  '{3'd3, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h100, 32'h81138013, 3'b000},
  '{3'd3, 1'b1, M_BR, 1'b0, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3'b000},
  '{3'd3, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h80, 32'h41134013, 3'b000},
  '{3'd3, 1'b1, M_MR, 1'b0, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3'b000},
  '{3'd3, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'hC0, 32'h61136013, 3'b000},
  '{3'd3, 1'b1, M_TR, 1'b0, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3'b000},
  '{3'd3, 1'b0, M_BT, 1'b0, 1'b1, 4'd0, 1'b1, 1'b0, 1'b1, 32'h180, 32'hC113C013, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h184, 32'hC313C213, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h188, 32'hC513C413, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h18C, 32'hC713C613, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b1, 1'b1, 32'h190, 32'h0, 3'b001},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h190, 32'hC913C813, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h194, 32'hCB13CA13, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h198, 32'hCD13CC13, 3'b000},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b1, 1'b1, 32'h19C, 32'h0, 3'b001},
  '{3'd5, 1'b0, M_BT, 1'b0, 1'b1, 4'd3, 1'b1, 1'b0, 1'b1, 32'h19C, 32'hCF13CE13, 3'b000},
  '{3'd6, 1'b1, M_JP, 1'b0, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 3'b000}
};

`endif

//--- test/if_stage_tb.sv
// Fetch stage testbench
// Table driven directed cycles, then random id_ready stalls checked
// against a small model, with a half-word ROM on the fetch port

`timescale 1ns/1ps
`default_nettype none

module if_stage_tb;

  localparam int RAND_CYCLES = 40;
  localparam logic [31:0] LCG_SEED = 32'd47254;

  `include "if_stage_tb_table.svh"

  // Directed rows, random cycles and some slack for reset
  localparam int TIMEOUT_CYCLES = NUM_ROWS + RAND_CYCLES + 20;

  logic                              clk;
  logic                              rst_n;
  logic                              pc_set_i;
  if_pkg::pc_mux_e                   pc_mux_i;
  logic                              halt_i;
  logic [if_pkg::DUMMY_CNT_W-1:0]    dummy_every_i;
  logic                              id_ready_i;
  logic [31:0]                       instr_addr_o;
  logic [31:0]                       instr_rdata_i;
  logic                              id_valid_o;
  logic [31:0]                       id_instr_o;
  logic [31:0]                       id_pc_o;
  logic                              id_compressed_o;
  logic                              id_illegal_o;
  logic                              id_dummy_o;

  logic [15:0] rom [256];
  logic [7:0]  rom_idx;
  logic [7:0]  rom_idx_next;
  logic [15:0] lfsr_mdl;
  logic [31:0] lcg_state;
  // Random phase model of the ID register
  logic        m_valid;
  logic [31:0] m_pc;
  logic [31:0] m_instr;
  logic [31:0] m_fetch;
  int          cycle_cnt = 0;
  int          cur_test = 0;
  int          test_errs = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  if_stage_top if_stage_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (BOOT_ADDR),
    .jump_target_i   (JUMP_ADDR),
    .branch_target_i (BRANCH_ADDR),
    .mepc_i          (MEPC_ADDR),
    .mtvec_addr_i    (MTVEC_BASE),
    .halt_i          (halt_i),
    .dummy_every_i   (dummy_every_i),
    .id_ready_i      (id_ready_i),
    .instr_addr_o    (instr_addr_o),
    .instr_rdata_i   (instr_rdata_i),
    .id_valid_o      (id_valid_o),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o),
    .id_illegal_o    (id_illegal_o),
    .id_dummy_o      (id_dummy_o)
  );

  // ROM returns 32 bits from any half-word address in the same cycle
  assign rom_idx       = instr_addr_o[8:1];
  assign rom_idx_next  = rom_idx + 8'd1;
  assign instr_rdata_i = {rom[rom_idx_next], rom[rom_idx]};

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Models
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] rom_word(input logic [31:0] addr);
    logic [7:0] idx;
    idx = addr[8:1];
    return {rom[idx + 8'd1], rom[idx]};
  endfunction

  // Fibonacci shift with taps 16 14 13 11 counted from 1
  function automatic logic [if_pkg::LFSR_W-1:0] lfsr_step(input logic [if_pkg::LFSR_W-1:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "sequential 32-bit fetch";
      2: return "compressed expansion";
      3: return "redirect sources";
      4: return "back-pressure and halt";
      5: return "dummy insertion";
      default: return "random id_ready stalls";
    endcase
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
      test_errs++;
    end
  endtask

  // id_valid_o is always compared and the payload only when asked
  task automatic check_outputs(input logic exp_valid, input logic chk_all,
                               input logic [31:0] exp_pc, input logic [31:0] exp_instr,
                               input logic [2:0] exp_flags);
    check_value("id_valid_o", 32'(id_valid_o), 32'(exp_valid));
    if (chk_all) begin
      check_value("id_pc_o", id_pc_o, exp_pc);
      check_value("id_instr_o", id_instr_o, exp_instr);
      check_value("id_compressed_o", 32'(id_compressed_o), 32'(exp_flags[2]));
      check_value("id_illegal_o", 32'(id_illegal_o), 32'(exp_flags[1]));
      check_value("id_dummy_o", 32'(id_dummy_o), 32'(exp_flags[0]));
    end
  endtask

  task automatic close_test();
    if (cur_test != 0) begin
      if (test_errs == 0) begin
        tests_passed++;
        $display("test %0d %s: ok", cur_test, test_name(cur_test));
      end else begin
        tests_failed++;
        $display("test %0d %s: %0d errors", cur_test, test_name(cur_test), test_errs);
      end
    end
    test_errs = 0;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    row_t        row;
    logic [31:0] exp_instr;
    clk           = 1'b0;
    rst_n         = 1'b0;
    pc_set_i      = 1'b0;
    pc_mux_i      = if_pkg::PC_BOOT;
    halt_i        = 1'b0;
    dummy_every_i = '0;
    id_ready_i    = 1'b0;
    lfsr_mdl      = if_pkg::LFSR_SEED;
    lcg_state     = LCG_SEED;
    for (int i = 0; i < 256; i++) begin
      rom[i] = rom_fill(8'(i));
    end
    for (int k = 0; k < ROM_PATCHES; k++) begin
      rom[ROM_PATCH[k][23:16]] = ROM_PATCH[k][15:0];
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Directed rows with outputs compared just after the rising edge
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = STIM_TABLE[r];
      if (int'(row.test) != cur_test) begin
        close_test();
        cur_test = int'(row.test);
      end
      @(negedge clk);
      pc_set_i      = row.pc_set;
      pc_mux_i      = if_pkg::pc_mux_e'(row.mux);
      halt_i        = row.halt;
      id_ready_i    = row.ready;
      dummy_every_i = row.every;
      exp_instr     = row.instr;
      if (row.lfsr) begin
        // addi x0, x0 with the low 12 LFSR bits
        exp_instr = {lfsr_mdl[11:0], 20'h00013};
        lfsr_mdl  = lfsr_step(lfsr_mdl);
      end
      @(posedge clk);
      #1;
      check_outputs(row.valid, row.chk, row.pc, exp_instr, row.flags);
    end

    // Last row jumped into plain 32-bit fill
    m_valid = 1'b0;
    m_pc    = '0;
    m_instr = '0;
    m_fetch = JUMP_ADDR;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(negedge clk);
      pc_set_i   = 1'b0;
      lcg_state  = lcg_next(lcg_state);
      id_ready_i = lcg_state[16];
      // Fetch is valid and ready alone decides the issue
      if (id_ready_i) begin
        m_valid = 1'b1;
        m_pc    = m_fetch;
        m_instr = rom_word(m_fetch);
        m_fetch = m_fetch + 32'd4;
      end
      @(posedge clk);
      #1;
      check_outputs(m_valid, m_valid, m_pc, m_instr, 3'b000);
      // ROM address moves on only after an issue
      check_value("instr_addr_o", instr_addr_o, m_fetch);
    end
    close_test();

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- if_stage.f
+incdir+include
src/if_pkg.sv
src/rvc_pkg.sv
src/if_fetch_unit.sv
src/rvc_expander.sv
src/dummy_insert_gen.sv
src/if_id_regs.sv
src/if_stage_top.sv
test/if_stage_tb.sv

//--- Makefile
# Verilator build and run for the instruction fetch stage testbench

VERILATOR ?= verilator
TOP       ?= if_stage_tb
FILELIST  ?= if_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

PASS_MSG  := === PASS ===
SOURCES   := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, not the simulator exit code
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
